//--- Makefile
VERILATOR  ?= verilator
TOP        := tbExecuteUnit
FILELIST   := all.f
OBJDIR     := obj_dir
LINTFLAGS  := --lint-only --timing --assert
SIMFLAGS   := --binary --timing --assert -Mdir $(OBJDIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- all.f
rtl/aluPkg.sv
rtl/instrPkg.sv
rtl/aluCore.sv
rtl/branchCompare.sv
rtl/executeRetire.sv
rtl/executeUnit.sv
testbench/executeUnit_assert.sv
testbench/tbExecuteUnit.sv

//--- rtl/aluCore.sv
`timescale 1ns/1ps

module aluCore (
    input  instrPkg::instrWord           instr,
    input  logic [aluPkg::dataWidth-1:0] opA,          // rs value
    input  logic [aluPkg::dataWidth-1:0] opB,          // rt value
    output logic [aluPkg::dataWidth-1:0] aluResult,
    output logic                         aluWrite,
    output logic                         aluIllegal,
    output logic                         aluZero,
    output logic                         aluNegative,
    output logic                         aluCarry,
    output logic                         aluOverflow
);
    import aluPkg::*;

    logic [5:0]         opcode;
    logic [5:0]         funct;
    logic [4:0]         shamt;
    logic [4:0]         regShift;       // Variable shift amount
    logic [dataWidth:0] sumExt;         // Carry in top bit
    logic [dataWidth:0] diffExt;        // Borrow in top bit
    logic               addOverflow;
    logic               subOverflow;
    logic               lessSigned;
    logic               lessUnsigned;
    logic [5:0]         leadZeros;
    logic [5:0]         leadOnes;
    logic               isRType;
    logic               funcKnown;      // Funct decoded to a real operation
    logic               moveKeep;       // Low when MOVZ/MOVN test fails

    // Leading zero count, 0 to 32
    function automatic logic [5:0] countLeadZeros(input logic [dataWidth-1:0] value);
        logic [5:0] count;
        count = 6'(dataWidth);                          // All clear
        for (int i = 0; i < dataWidth; i++)
        begin
            if (value[i])
                count = 6'(dataWidth - 1 - i);          // Highest set bit wins
        end
        return count;
    endfunction

    // Field extraction through the register view
    assign opcode   = instr.r.opcode;
    assign funct    = instr.r.funct;
    assign shamt    = instr.r.shamt;
    assign regShift = opA[4:0];
    assign isRType  = (opcode == opSpecial);

    // Shared adder and subtractor
    assign sumExt  = {1'b0, opA} + {1'b0, opB};
    assign diffExt = {1'b0, opA} - {1'b0, opB};

    // Signed overflow
    // Add overflows when like signs give an unlike sign
    assign addOverflow = (opA[dataWidth-1] == opB[dataWidth-1])
                       && (sumExt[dataWidth-1] != opA[dataWidth-1]);
    // Sub overflows when unlike signs flip the sign of opA
    assign subOverflow = (opA[dataWidth-1] != opB[dataWidth-1])
                       && (diffExt[dataWidth-1] != opA[dataWidth-1]);

    assign lessSigned   = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;

    assign leadZeros = countLeadZeros(opA);
    assign leadOnes  = countLeadZeros(~opA);           // CLO as CLZ of inverse

    always_comb
    begin
        aluResult   = '0;
        aluCarry    = 1'b0;
        aluOverflow = 1'b0;
        funcKnown   = 1'b1;
        moveKeep    = 1'b1;
        if (isRType)
        begin
            case (funct)
                funcSll:  aluResult = opB << shamt;
                funcSrl:  aluResult = opB >> shamt;
                funcSra:  aluResult = $signed(opB) >>> shamt;
                funcSllv: aluResult = opB << regShift;
                funcSrlv: aluResult = opB >> regShift;
                funcSrav: aluResult = $signed(opB) >>> regShift;
                funcMovz:
                begin
                    aluResult = opA;
                    moveKeep  = (opB == '0);            // Write only if rt is zero
                end
                funcMovn:
                begin
                    aluResult = opA;
                    moveKeep  = (opB != '0);
                end
                funcClo:  aluResult = dataWidth'(leadOnes);
                funcClz:  aluResult = dataWidth'(leadZeros);
                funcAdd:
                begin
                    aluResult   = sumExt[dataWidth-1:0];
                    aluCarry    = sumExt[dataWidth];
                    aluOverflow = addOverflow;
                end
                funcAddu:
                begin
                    aluResult = sumExt[dataWidth-1:0];
                    aluCarry  = sumExt[dataWidth];      // No overflow for unsigned
                end
                funcSub:
                begin
                    aluResult   = diffExt[dataWidth-1:0];
                    aluCarry    = diffExt[dataWidth];   // Borrow
                    aluOverflow = subOverflow;
                end
                funcSubu:
                begin
                    aluResult = diffExt[dataWidth-1:0];
                    aluCarry  = diffExt[dataWidth];
                end
                funcAnd:  aluResult = opA & opB;
                funcOr:   aluResult = opA | opB;
                funcXor:  aluResult = opA ^ opB;
                funcNor:  aluResult = ~(opA | opB);
                funcSlt:  aluResult = {{(dataWidth-1){1'b0}}, lessSigned};    // 1 when opA < opB
                funcSltu: aluResult = {{(dataWidth-1){1'b0}}, lessUnsigned};
                default:  funcKnown = 1'b0;             // Unknown funct
            endcase
        end
    end

    // Status flags follow the result for every operation
    assign aluZero     = (aluResult == '0);
    assign aluNegative = aluResult[dataWidth-1];

    // Non-R-type words are neither written nor flagged here
    assign aluWrite   = isRType && funcKnown && moveKeep;
    assign aluIllegal = isRType && !funcKnown;

endmodule

//--- rtl/aluPkg.sv
package aluPkg;

    // Operand and result width
    localparam int dataWidth = 32;

    // R-type function codes, opcode 0

    // Shifts by shamt
    localparam logic [5:0] funcSll  = 6'b000000;
    localparam logic [5:0] funcSrl  = 6'b000010;
    localparam logic [5:0] funcSra  = 6'b000011;

    // Shifts by register, amount from rs
    localparam logic [5:0] funcSllv = 6'b000100;
    localparam logic [5:0] funcSrlv = 6'b000110;
    localparam logic [5:0] funcSrav = 6'b000111;

    // Conditional moves
    localparam logic [5:0] funcMovz = 6'b001010;
    localparam logic [5:0] funcMovn = 6'b001011;

    // Bit counting, kept under opcode 0 rather than SPECIAL2
    localparam logic [5:0] funcClo  = 6'b011100;
    localparam logic [5:0] funcClz  = 6'b011101;

    localparam logic [5:0] funcAdd  = 6'b100000;    // Signed, overflow reported
    localparam logic [5:0] funcAddu = 6'b100001;
    localparam logic [5:0] funcSub  = 6'b100010;    // Signed, overflow reported
    localparam logic [5:0] funcSubu = 6'b100011;

    // Bitwise logic
    localparam logic [5:0] funcAnd  = 6'b100100;
    localparam logic [5:0] funcOr   = 6'b100101;
    localparam logic [5:0] funcXor  = 6'b100110;
    localparam logic [5:0] funcNor  = 6'b100111;

    localparam logic [5:0] funcSlt  = 6'b101010;    // Signed compare
    localparam logic [5:0] funcSltu = 6'b101011;    // Unsigned compare

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'b000000;   // R-type group
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opBlez    = 6'b000110;
    localparam logic [5:0] opBgtz    = 6'b000111;

endpackage

//--- rtl/branchCompare.sv
`timescale 1ns/1ps

module branchCompare (
    input  instrPkg::instrWord           instr,
    input  logic [aluPkg::dataWidth-1:0] opA,          // rs value
    input  logic [aluPkg::dataWidth-1:0] opB,          // rt value
    output logic                         branchTaken,
    output logic                         branchIllegal
);
    import aluPkg::*;

    logic [5:0] opcode;
    logic       equalOps;
    logic       aNegative;
    logic       aZero;

    // Opcode through the immediate view
    assign opcode = instr.i.opcode;

    assign equalOps  = (opA == opB);
    assign aNegative = opA[dataWidth-1];        // Sign of rs
    assign aZero     = (opA == '0);

    always_comb
    begin
        branchTaken   = 1'b0;
        branchIllegal = 1'b0;
        case (opcode)
            opSpecial: ;                        // ALU owns this group
            opBeq:
                branchTaken = equalOps;
            opBne:
                branchTaken = !equalOps;
            opBlez:
                branchTaken = aNegative || aZero;   // Signed rs <= 0
            opBgtz:
                branchTaken = !aNegative && !aZero; // Signed rs > 0
            default:
            begin
                // Immediate arithmetic, jumps and the rest not handled
                branchIllegal = 1'b1;
            end
        endcase
    end

endmodule

//--- rtl/executeRetire.sv
`timescale 1ns/1ps

module executeRetire (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         inValid,
    // ALU outcome
    input  logic [aluPkg::dataWidth-1:0] aluResult,
    input  logic                         aluWrite,
    input  logic                         aluIllegal,
    input  logic                         aluZero,
    input  logic                         aluNegative,
    input  logic                         aluCarry,
    input  logic                         aluOverflow,
    // Branch outcome
    input  logic                         condTaken,
    input  logic                         branchIllegal,
    // Registered record
    output logic                         outValid,
    output logic [aluPkg::dataWidth-1:0] result,
    output logic                         writeEnable,
    output logic                         branchTaken,
    output logic                         zeroFlag,
    output logic                         negativeFlag,
    output logic                         carryFlag,
    output logic                         overflowFlag,
    output logic                         illegalOp
);

    // Control half, cleared on reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            outValid    <= 1'b0;
            writeEnable <= 1'b0;
            branchTaken <= 1'b0;
            illegalOp   <= 1'b0;
        end
        else
        begin
            outValid    <= inValid;                     // One cycle behind the strobe
            writeEnable <= inValid && aluWrite;
            branchTaken <= inValid && condTaken;
            // Either decoder can reject the word
            illegalOp   <= inValid && (aluIllegal || branchIllegal);
        end
    end

    // Data half
    // Holds last value across idle cycles
    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            result       <= aluResult;
            zeroFlag     <= aluZero;
            negativeFlag <= aluNegative;
            carryFlag    <= aluCarry;
            overflowFlag <= aluOverflow;
        end
    end

endmodule

//--- rtl/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         inValid,      // Instruction strobe
    input  instrPkg::instrWord           instr,
    input  logic [aluPkg::dataWidth-1:0] opA,          // rs value
    input  logic [aluPkg::dataWidth-1:0] opB,          // rt value
    output logic                         outValid,
    output logic [aluPkg::dataWidth-1:0] result,
    output logic                         writeEnable,
    output logic                         branchTaken,
    output logic                         zeroFlag,
    output logic                         negativeFlag,
    output logic                         carryFlag,
    output logic                         overflowFlag,
    output logic                         illegalOp
);
    import aluPkg::*;

    // ALU to retire
    logic [dataWidth-1:0] aluResult;
    logic                 aluWrite;
    logic                 aluIllegal;
    logic                 aluZero;
    logic                 aluNegative;
    logic                 aluCarry;
    logic                 aluOverflow;

    // Branch to retire
    logic                 condTaken;
    logic                 branchIllegal;

    // Both decoders see the same word in the same cycle
    aluCore aluCore_i (
        .instr       (instr),
        .opA         (opA),
        .opB         (opB),
        .aluResult   (aluResult),
        .aluWrite    (aluWrite),
        .aluIllegal  (aluIllegal),
        .aluZero     (aluZero),
        .aluNegative (aluNegative),
        .aluCarry    (aluCarry),
        .aluOverflow (aluOverflow)
    );

    branchCompare branchCompare_i (
        .instr         (instr),
        .opA           (opA),
        .opB           (opB),
        .branchTaken   (condTaken),
        .branchIllegal (branchIllegal)
    );

    // Single register stage
    executeRetire executeRetire_i (
        .clk           (clk),
        .reset         (reset),
        .inValid       (inValid),
        .aluResult     (aluResult),
        .aluWrite      (aluWrite),
        .aluIllegal    (aluIllegal),
        .aluZero       (aluZero),
        .aluNegative   (aluNegative),
        .aluCarry      (aluCarry),
        .aluOverflow   (aluOverflow),
        .condTaken     (condTaken),
        .branchIllegal (branchIllegal),
        .outValid      (outValid),
        .result        (result),
        .writeEnable   (writeEnable),
        .branchTaken   (branchTaken),
        .zeroFlag      (zeroFlag),
        .negativeFlag  (negativeFlag),
        .carryFlag     (carryFlag),
        .overflowFlag  (overflowFlag),
        .illegalOp     (illegalOp)
    );

endmodule

//--- rtl/instrPkg.sv
package instrPkg;

    // Register format, ALU operations
    typedef struct packed {
        logic [5:0] opcode;     // Always 0 for R-type
        logic [4:0] rs;         // First source
        logic [4:0] rt;         // Second source
        logic [4:0] rd;         // Destination
        logic [4:0] shamt;      // Shift amount for immediate shifts
        logic [5:0] funct;      // Selects the ALU operation
    } rFormat;

    // Immediate format, branches
    typedef struct packed {
        logic [5:0]  opcode;    // Branch kind
        logic [4:0]  rs;        // Compared operand
        logic [4:0]  rt;        // Second operand for BEQ, BNE
        logic [15:0] imm;       // Offset, target math lives elsewhere
    } iFormat;

    // Same 32-bit word seen two ways
    // ALU reads r, branch comparator reads i
    typedef union packed {
        rFormat r;
        iFormat i;
    } instrWord;

endpackage

//--- testbench/executeUnit_assert.sv
`timescale 1ns/1ps

module executeUnitAssert (
    input logic clk,
    input logic reset,
    input logic inValid,
    input logic outValid,
    input logic writeEnable,
    input logic branchTaken,
    input logic illegalOp
);

    // Reset clears every control
    property resetClears;
        @(posedge clk) reset |=> !outValid && !writeEnable && !branchTaken && !illegalOp;
    endproperty
    assert property (resetClears) else $error("controls not low after reset");

    // Output strobe lags the input strobe by one edge
    property validFollows;
        @(posedge clk) !reset |=> (outValid == $past(inValid));
    endproperty
    assert property (validFollows) else $error("outValid does not follow inValid");

    property controlsNeedValid;
        @(posedge clk) (writeEnable || branchTaken || illegalOp) |-> outValid;
    endproperty
    assert property (controlsNeedValid) else $error("control high without outValid");

endmodule

//--- testbench/tbExecuteUnit.sv
`timescale 1ns/1ps

module tbExecuteUnit;
    import aluPkg::*;
    import instrPkg::*;

    logic                 clk;
    logic                 reset;
    logic                 inValid;
    instrWord             instr;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic                 outValid;
    logic [dataWidth-1:0] result;
    logic                 writeEnable;
    logic                 branchTaken;
    logic                 zeroFlag;
    logic                 negativeFlag;
    logic                 carryFlag;
    logic                 overflowFlag;
    logic                 illegalOp;
    logic [31:0]          lfsrState = 32'hbc61423e;

    executeUnit dut_i (.*);
    bind executeUnit executeUnitAssert executeUnitAssert_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    // Galois LFSR, taps 32,30,26,25
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? 32'ha3000000 : 32'h0);
    endfunction

    task automatic randomBits(input int count, output logic [31:0] value);
        value = '0;
        for (int n = 0; n < count; n++)
        begin
            value     = {value[30:0], lfsrState[0]};    // One step per bit
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    task automatic reportMismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic compareResult(input logic [dataWidth-1:0] got, exp, input string what);
        if (got !== exp)
            reportMismatch($sformatf("%s result %h expected %h", what, got, exp));
    endtask

    // Flags packed as zero, negative, carry, overflow
    task automatic compareFlags(input logic [3:0] got, exp, input string what);
        if (got !== exp)
            reportMismatch($sformatf("%s flags %b expected %b", what, got, exp));
    endtask

    // Controls packed as writeEnable, branchTaken, illegalOp
    task automatic compareControl(input logic [2:0] got, exp, input string what);
        if (got !== exp)
            reportMismatch($sformatf("%s controls %b expected %b", what, got, exp));
    endtask

    function automatic instrWord makeR(input logic [5:0] funct, input logic [4:0] shamt);
        instrWord w;
        w.r = '{opcode: opSpecial, rs: 5'd1, rt: 5'd2, rd: 5'd3, shamt: shamt, funct: funct};
        return w;
    endfunction

    function automatic instrWord makeI(input logic [5:0] opcode);
        instrWord w;
        w.i = '{opcode: opcode, rs: 5'd4, rt: 5'd5, imm: 16'h0010};
        return w;
    endfunction

    // Reference model of the ALU rules
    task automatic predictAlu(input logic [5:0] funct, input logic [4:0] shamt,
                              input logic [31:0] a, b, output logic [31:0] res,
                              output logic carry, ovf, write, illegal);
        logic [32:0] wide;
        longint      exact;
        int          lead;
        bit          stop;
        logic [4:0]  amount;
        res     = '0;
        carry   = 1'b0;
        ovf     = 1'b0;
        write   = 1'b1;
        illegal = 1'b0;
        lead    = 0;
        stop    = 1'b0;
        amount  = (funct inside {funcSllv, funcSrlv, funcSrav}) ? a[4:0] : shamt;
        case (funct)
            funcSll, funcSllv: res = b << amount;
            funcSrl, funcSrlv: res = b >> amount;
            funcSra, funcSrav: res = (b >> amount) | (b[31] ? ~(32'hffffffff >> amount) : 32'h0);
            funcAnd:  res = a & b;
            funcOr:   res = a | b;
            funcXor:  res = a ^ b;
            funcNor:  res = ~(a | b);
            funcAdd, funcAddu:
            begin
                wide  = {1'b0, a} + {1'b0, b};
                res   = wide[31:0];
                carry = wide[32];
                exact = longint'($signed(a)) + longint'($signed(b));
                ovf   = (funct == funcAdd) && (exact != longint'($signed(res)));
            end
            funcSub, funcSubu:
            begin
                res   = a - b;
                carry = a < b;                  // Borrow
                exact = longint'($signed(a)) - longint'($signed(b));
                ovf   = (funct == funcSub) && (exact != longint'($signed(res)));
            end
            funcSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            funcSltu: res = (a < b) ? 32'd1 : 32'd0;
            funcMovz, funcMovn:
            begin
                res   = a;
                write = (funct == funcMovz) ? (b == '0) : (b != '0);
            end
            funcClz, funcClo:
            begin
                for (int k = 31; k >= 0; k--)
                begin
                    if (!stop && (a[k] == (funct == funcClo)))
                        lead++;
                    else
                        stop = 1'b1;            // First differing bit ends the run
                end
                res = 32'(lead);
            end
            default:
            begin
                write   = 1'b0;
                illegal = 1'b1;
            end
        endcase
    endtask

    // One instruction in, wait for its record
    task automatic issue(input instrWord w, input logic [31:0] a, b);
        int waited;
        waited = 0;
        @(negedge clk);
        inValid = 1'b1;
        instr   = w;
        opA     = a;
        opB     = b;
        @(negedge clk);
        inValid = 1'b0;
        while (outValid !== 1'b1)
        begin
            if (waited >= 8)
            begin
                $display("Timed out waiting for outValid after an instruction");
                $display("Simulation failed");
                $fatal(1, "no output record");
            end
            else
            begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic checkAlu(input logic [5:0] funct, input logic [4:0] shamt,
                            input logic [31:0] a, b);
        logic [31:0] res;
        logic        carry;
        logic        ovf;
        logic        write;
        logic        illegal;
        string       what;
        what = $sformatf("funct %b a %h b %h", funct, a, b);
        predictAlu(funct, shamt, a, b, res, carry, ovf, write, illegal);
        issue(makeR(funct, shamt), a, b);
        if (!illegal)
        begin
            compareResult(result, res, what);
            compareFlags({zeroFlag, negativeFlag, carryFlag, overflowFlag},
                         {res == '0, res[31], carry, ovf}, what);
        end
        compareControl({writeEnable, branchTaken, illegalOp}, {write, 1'b0, illegal}, what);
    endtask

    task automatic checkBranch(input logic [5:0] opcode, input logic [31:0] a, b);
        logic taken;
        case (opcode)
            opBeq:   taken = (a == b);
            opBne:   taken = (a != b);
            opBlez:  taken = ($signed(a) <= 0);
            default: taken = ($signed(a) > 0);  // BGTZ
        endcase
        issue(makeI(opcode), a, b);
        compareControl({writeEnable, branchTaken, illegalOp}, {1'b0, taken, 1'b0},
                       $sformatf("branch %b a %h b %h", opcode, a, b));
    endtask

    task automatic testLogicShifts();
        logic [5:0]  ops [10] = '{funcAnd, funcOr, funcXor, funcNor, funcSll,
                                  funcSrl, funcSra, funcSllv, funcSrlv, funcSrav};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sh;
        for (int n = 0; n < 40; n++)
        begin
            randomBits(32, a);
            randomBits(32, b);
            randomBits(5, sh);
            checkAlu(ops[n % 10], sh[4:0], a, b);
        end
    endtask

    task automatic testArithmetic();
        logic [5:0]  ops [4] = '{funcAdd, funcAddu, funcSub, funcSubu};
        logic [31:0] edges [5] = '{32'h7fffffff, 32'h80000000, 32'h0, 32'hffffffff, 32'h1};
        logic [31:0] a;
        logic [31:0] b;
        foreach (ops[o])
        begin
            foreach (edges[x])
                foreach (edges[y])
                    checkAlu(ops[o], 5'd0, edges[x], edges[y]);
            for (int n = 0; n < 6; n++)
            begin
                randomBits(32, a);
                randomBits(32, b);
                checkAlu(ops[o], 5'd0, a, b);
            end
        end
    endtask

    task automatic testCompareMoveCount();
        logic [31:0] a;
        logic [31:0] countVals [6];
        randomBits(32, a);
        countVals = '{32'h0, 32'hffffffff, 32'h1, 32'h80000000, a, ~a};
        checkAlu(funcSlt, 5'd0, 32'hffffffff, 32'h1);   // Signed less, unsigned not
        checkAlu(funcSltu, 5'd0, 32'hffffffff, 32'h1);
        checkAlu(funcSlt, 5'd0, 32'h1, 32'hffffffff);
        checkAlu(funcSltu, 5'd0, 32'h1, 32'hffffffff);
        checkAlu(funcMovz, 5'd0, a, 32'h0);
        checkAlu(funcMovz, 5'd0, a, 32'h5);             // Write suppressed
        checkAlu(funcMovn, 5'd0, a, 32'h0);
        checkAlu(funcMovn, 5'd0, a, 32'h5);
        foreach (countVals[k])
        begin
            checkAlu(funcClz, 5'd0, countVals[k], 32'h0);
            checkAlu(funcClo, 5'd0, countVals[k], 32'h0);
        end
    endtask

    task automatic testBranches();
        logic [31:0] vals [3] = '{32'h80000004, 32'h0, 32'h00000007};   // Neg, zero, pos
        foreach (vals[k])
        begin
            checkBranch(opBeq, vals[k], vals[k]);
            checkBranch(opBeq, vals[k], vals[k] + 1);
            checkBranch(opBne, vals[k], vals[k]);
            checkBranch(opBne, vals[k], vals[k] + 1);
            checkBranch(opBlez, vals[k], 32'h0);
            checkBranch(opBgtz, vals[k], 32'h0);
        end
    endtask

    task automatic testIllegalPipeline();
        logic [5:0]  ops [3] = '{funcAdd, funcXor, funcSltu};
        logic [31:0] a [3];
        logic [31:0] b [3];
        logic [31:0] exp [3];
        logic        c;
        logic        v;
        logic        w;
        logic        il;
        checkAlu(6'b111111, 5'd0, 32'h1, 32'h2);        // Unknown funct
        issue(makeI(6'b001000), 32'h1, 32'h2);          // Unknown opcode
        compareControl({writeEnable, branchTaken, illegalOp}, 3'b001, "unknown opcode");
        foreach (ops[k])
        begin
            randomBits(32, a[k]);
            randomBits(32, b[k]);
            predictAlu(ops[k], 5'd0, a[k], b[k], exp[k], c, v, w, il);
        end
        // Sample then drive on each falling edge, one record per cycle
        for (int k = 0; k <= 3; k++)
        begin
            @(negedge clk);
            if (k > 0)
            begin
                if (outValid !== 1'b1)
                    reportMismatch($sformatf("back-to-back record %0d missing", k - 1));
                compareResult(result, exp[k-1], $sformatf("back-to-back %0d", k - 1));
            end
            inValid = (k < 3);
            if (k < 3)
            begin
                instr = makeR(ops[k], 5'd0);
                opA   = a[k];
                opB   = b[k];
            end
        end
        @(negedge clk);
        if (outValid !== 1'b0)
            reportMismatch("outValid high on idle cycle");
        compareControl({writeEnable, branchTaken, illegalOp}, 3'b000, "idle cycle");
    endtask

    initial
    begin
        reset   = 1'b1;
        inValid = 1'b0;
        instr   = '0;
        opA     = '0;
        opB     = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        testLogicShifts();
        testArithmetic();
        testCompareMoveCount();
        testBranches();
        testIllegalPipeline();
        $display("Simulation passed");
        $finish;
    end

endmodule
